// File: ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    // bus widths
    localparam int haddr_width = 32;
    localparam int hdata_width = 32;

    // htrans, only idle and nonseq are issued by this master
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_nonseq = 2'b10;

    // hsize for a full 32-bit word
    localparam logic [2:0] hsize_word = 3'b010;

    // hburst single transfer
    localparam logic [2:0] hburst_single = 3'b000;

    // hprot, bit 0 set marks a data access
    localparam logic [3:0] hprot_data = 4'b0001;

endpackage

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // load/store operations, bit 3 set for stores
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_e;

    // one data word seen as byte lanes or halfword lanes
    // lane 0 sits at the low address (little endian)
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

    // pipeline stall vector, one bit per stage
    localparam int stall_width   = 6;
    localparam int stall_mem_bit = 4;

endpackage

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_i,
    input  lsu_pkg::mem_op_e                  op_i,
    input  logic [31:0]                       addr_i,
    input  logic [31:0]                       wdata_i,
    input  logic                              hold_i,
    input  logic [31:0]                       rdata_i,
    input  logic                              stallreq_i,
    output logic                              done_o,
    output logic [31:0]                       load_data_o,
    output logic                              re_o,
    output logic                              we_o,
    output logic [31:0]                       maddr_o,
    output logic [31:0]                       mwdata_o,
    output logic [lsu_pkg::stall_width-1:0]   stall_o
);

    localparam logic [1:0] ph_idle  = 2'b00;
    localparam logic [1:0] ph_read  = 2'b01;
    localparam logic [1:0] ph_merge = 2'b10;
    localparam logic [1:0] ph_write = 2'b11;

    logic [1:0]          phase;
    logic                done_r;
    logic                is_store;
    logic                is_word_store;
    logic                xfer_done;
    logic                last_done;
    logic [31:0]         wbuf;
    lsu_pkg::data_word_u rd_word;
    lsu_pkg::data_word_u mg_word;

    // every stage stalls together, as the control unit does
    assign stall_o = {lsu_pkg::stall_width{stallreq_i | hold_i}};

    always_comb begin
        is_store      = (op_i == lsu_pkg::op_sb) || (op_i == lsu_pkg::op_sh) ||
                        (op_i == lsu_pkg::op_sw);
        is_word_store = (op_i == lsu_pkg::op_sw);
    end

    // master leaves READ_WAIT or WRITE exactly when the memory bit drops
    assign xfer_done = ((phase == ph_read) || (phase == ph_write)) &&
                       !stall_o[lsu_pkg::stall_mem_bit];
    assign last_done = xfer_done && ((phase == ph_write) || !is_store);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= ph_idle;
            done_r <= 1'b0;
        end else begin
            // pending done waits out back-pressure
            done_r <= last_done || (done_r && hold_i);
            case (phase)
                ph_idle: begin
                    if (req_i && !done_r) begin
                        phase <= is_word_store ? ph_write : ph_read;
                    end
                end
                ph_read: begin
                    if (xfer_done) begin
                        phase <= is_store ? ph_merge : ph_idle;
                    end
                end
                ph_merge: begin
                    phase <= ph_write;
                end
                ph_write: begin
                    if (xfer_done) begin
                        phase <= ph_idle;
                    end
                end
            endcase
        end
    end

    // write word: full store data, or the merged read word
    always_ff @(posedge clk) begin
        if ((phase == ph_idle) && req_i && !done_r && is_word_store) begin
            wbuf <= wdata_i;
        end else if (phase == ph_merge) begin
            wbuf <= mg_word;
        end
    end

    // sub-word merge into the word just read
    always_comb begin
        mg_word = rdata_i;
        if (op_i == lsu_pkg::op_sb) begin
            mg_word.bytes[addr_i[1:0]] = wdata_i[7:0];
        end else if (op_i == lsu_pkg::op_sh) begin
            mg_word.halves[addr_i[1]] = wdata_i[15:0];
        end
    end

    // lane select and extension for loads
    always_comb begin
        rd_word = rdata_i;
        case (op_i)
            lsu_pkg::op_lb:  load_data_o = {{24{rd_word.bytes[addr_i[1:0]][7]}},
                                            rd_word.bytes[addr_i[1:0]]};
            lsu_pkg::op_lbu: load_data_o = {24'h0, rd_word.bytes[addr_i[1:0]]};
            lsu_pkg::op_lh:  load_data_o = {{16{rd_word.halves[addr_i[1]][15]}},
                                            rd_word.halves[addr_i[1]]};
            lsu_pkg::op_lhu: load_data_o = {16'h0, rd_word.halves[addr_i[1]]};
            default:         load_data_o = rd_word;
        endcase
    end

    assign done_o   = done_r && !hold_i;
    assign re_o     = (phase == ph_read);
    assign we_o     = (phase == ph_write);
    assign maddr_o  = {addr_i[31:2], 2'b00};
    assign mwdata_o = wbuf;

endmodule

`default_nettype wire

// File: ls_ahb_interface.sv
`timescale 1ns/1ps
`default_nettype none

module ls_ahb_interface (
    input  logic                              clk,
    input  logic                              rst_n,

    // load/store client
    input  logic                              re_i,
    input  logic                              we_i,
    input  logic [ahb_pkg::haddr_width-1:0]   addr_i,
    input  logic [ahb_pkg::hdata_width-1:0]   wdata_i,
    output logic [ahb_pkg::hdata_width-1:0]   rdata_o,

    // pipeline control
    input  logic [lsu_pkg::stall_width-1:0]   stall_i,
    output logic                              stallreq_o,

    // ahb-lite master side
    output logic                              mst_hsel_o,
    output logic [1:0]                        mst_htrans_o,
    output logic [ahb_pkg::haddr_width-1:0]   mst_haddr_o,
    output logic [ahb_pkg::hdata_width-1:0]   mst_hwdata_o,
    output logic                              mst_hwrite_o,
    output logic [2:0]                        mst_hsize_o,
    output logic [2:0]                        mst_hburst_o,
    output logic [3:0]                        mst_hprot_o,
    output logic                              mst_hmastlock_o,
    output logic                              mst_priority_o,
    input  logic                              mst_hready_i,
    input  logic                              mst_hresp_i,
    input  logic [ahb_pkg::hdata_width-1:0]   mst_hrdata_i
);

    localparam logic [1:0] st_idle      = 2'b00;
    localparam logic [1:0] st_read      = 2'b01;
    localparam logic [1:0] st_write     = 2'b10;
    localparam logic [1:0] st_read_wait = 2'b11;

    logic [1:0]                      state;
    logic [1:0]                      next_state;
    logic                            mem_stall;
    logic [1:0]                      htrans_r;
    logic [ahb_pkg::hdata_width-1:0] hwdata_r;
    logic                            hmastlock_r;
    logic [ahb_pkg::hdata_width-1:0] rdata_r;

    assign mem_stall = stall_i[lsu_pkg::stall_mem_bit];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // read path idle -> read -> read_wait -> idle
    // write path idle -> write -> idle
    // read then write goes idle -> read -> write -> idle
    // idle and read ignore the stall vector
    always_comb begin
        next_state = st_idle;
        case (state)
            st_idle: begin
                if (re_i && mst_hready_i) begin
                    next_state = st_read;
                end else if (we_i && mst_hready_i) begin
                    next_state = st_write;
                end
            end
            st_read: begin
                if (!mst_hready_i) begin
                    next_state = st_read;
                end else if (we_i) begin
                    next_state = st_write;
                end else begin
                    next_state = st_read_wait;
                end
            end
            st_write: begin
                if (mst_hready_i && !mem_stall) begin
                    next_state = st_idle;
                end else begin
                    next_state = st_write;
                end
            end
            st_read_wait: begin
                if (!mem_stall) begin
                    next_state = st_idle;
                end else begin
                    next_state = st_read_wait;
                end
            end
        endcase
    end

    // htrans turns nonseq after reset and hwdata follows the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            htrans_r    <= ahb_pkg::htrans_idle;
            hwdata_r    <= '0;
            hmastlock_r <= 1'b0;
        end else begin
            htrans_r    <= ahb_pkg::htrans_nonseq;
            hmastlock_r <= 1'b1;
            case (state)
                st_idle: begin
                    hwdata_r <= (we_i && !re_i) ? wdata_i : '0;
                end
                st_read: begin
                    hwdata_r <= (mst_hready_i && we_i) ? wdata_i : '0;
                end
                st_write: begin
                    // held through wait states and back-pressure
                    if (mst_hready_i && !mem_stall) begin
                        hwdata_r <= '0;
                    end
                end
                st_read_wait: begin
                    hwdata_r <= '0;
                end
            endcase
        end
    end

    // read data sampled at the end of the data phase
    always_ff @(posedge clk) begin
        if ((state == st_read) && mst_hready_i) begin
            rdata_r <= mst_hrdata_i;
        end
    end

    assign rdata_o = rdata_r;

    // every transfer is a single word data access
    assign mst_hsel_o      = 1'b1;
    assign mst_htrans_o    = htrans_r;
    assign mst_haddr_o     = addr_i;
    assign mst_hwdata_o    = hwdata_r;
    assign mst_hwrite_o    = (state != st_write) && (next_state == st_write);
    assign mst_hsize_o     = ahb_pkg::hsize_word;
    assign mst_hburst_o    = ahb_pkg::hburst_single;
    assign mst_hprot_o     = ahb_pkg::hprot_data;
    assign mst_hmastlock_o = hmastlock_r;
    assign mst_priority_o  = 1'b0;

    // busy while starting, during wait states, and while leaving read
    assign stallreq_o = ((state == st_idle) &&
                         ((next_state == st_read) || (next_state == st_write))) ||
                        !mst_hready_i ||
                        ((state == st_read) &&
                         ((next_state == st_write) || (next_state == st_read_wait)));

endmodule

`default_nettype wire

// File: ahb_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave #(
    parameter int wait_states = 1,
    parameter int mem_words   = 256
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              hsel_i,
    input  logic [1:0]                        htrans_i,
    input  logic [ahb_pkg::haddr_width-1:0]   haddr_i,
    input  logic                              hwrite_i,
    input  logic [2:0]                        hsize_i,
    input  logic [ahb_pkg::hdata_width-1:0]   hwdata_i,
    output logic                              hready_o,
    output logic                              hresp_o,
    output logic [ahb_pkg::hdata_width-1:0]   hrdata_o
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    logic [ahb_pkg::hdata_width-1:0] mem [mem_words];
    logic                            accept;
    logic                            ph_valid;
    logic                            ph_write;
    logic [idx_w-1:0]                ph_idx;
    logic [cnt_w-1:0]                wait_cnt;

    // only word-sized nonseq transfers are served
    assign accept = hsel_i && (htrans_i == ahb_pkg::htrans_nonseq) &&
                    (hsize_i == ahb_pkg::hsize_word);

    // data phase ends once the wait count is reached
    assign hready_o = !ph_valid || (wait_cnt == cnt_w'(wait_states));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ph_valid <= 1'b0;
            ph_write <= 1'b0;
            wait_cnt <= '0;
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (hready_o) begin
            // finish the current data phase, take the next address phase
            if (ph_valid && ph_write) begin
                mem[ph_idx] <= hwdata_i;
            end
            ph_valid <= accept;
            ph_write <= hwrite_i;
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // word index of the accepted address
    always_ff @(posedge clk) begin
        if (hready_o) begin
            ph_idx <= haddr_i[idx_w+1:2];
        end
    end

    assign hrdata_o = mem[ph_idx];
    assign hresp_o  = 1'b0;

endmodule

`default_nettype wire

// File: mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
    parameter int wait_states = 1,
    parameter int mem_words   = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_i,
    input  lsu_pkg::mem_op_e op_i,
    input  logic [31:0]      addr_i,
    input  logic [31:0]      wdata_i,
    input  logic             hold_i,
    output logic             done_o,
    output logic [31:0]      load_data_o
);

    // memory stage to master
    logic                            re;
    logic                            we;
    logic [31:0]                     maddr;
    logic [31:0]                     mwdata;
    logic [lsu_pkg::stall_width-1:0] stall;
    logic [31:0]                     rdata;
    logic                            stallreq;

    // ahb-lite bus
    logic                            hsel;
    logic [1:0]                      htrans;
    logic [31:0]                     haddr;
    logic [31:0]                     hwdata;
    logic                            hwrite;
    logic [2:0]                      hsize;
    logic                            hready;
    logic                            hresp;
    logic [31:0]                     hrdata;

    mem_stage mem_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .hold_i      (hold_i),
        .rdata_i     (rdata),
        .stallreq_i  (stallreq),
        .done_o      (done_o),
        .load_data_o (load_data_o),
        .re_o        (re),
        .we_o        (we),
        .maddr_o     (maddr),
        .mwdata_o    (mwdata),
        .stall_o     (stall)
    );

    // hburst, hprot, hmastlock and priority have no consumer on this bus
    ls_ahb_interface ls_ahb_interface_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .re_i            (re),
        .we_i            (we),
        .addr_i          (maddr),
        .wdata_i         (mwdata),
        .rdata_o         (rdata),
        .stall_i         (stall),
        .stallreq_o      (stallreq),
        .mst_hsel_o      (hsel),
        .mst_htrans_o    (htrans),
        .mst_haddr_o     (haddr),
        .mst_hwdata_o    (hwdata),
        .mst_hwrite_o    (hwrite),
        .mst_hsize_o     (hsize),
        .mst_hburst_o    (),
        .mst_hprot_o     (),
        .mst_hmastlock_o (),
        .mst_priority_o  (),
        .mst_hready_i    (hready),
        .mst_hresp_i     (hresp),
        .mst_hrdata_i    (hrdata)
    );

    ahb_sram_slave #(
        .wait_states (wait_states),
        .mem_words   (mem_words)
    ) ahb_sram_slave_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .hsel_i   (hsel),
        .htrans_i (htrans),
        .haddr_i  (haddr),
        .hwrite_i (hwrite),
        .hsize_i  (hsize),
        .hwdata_i (hwdata),
        .hready_o (hready),
        .hresp_o  (hresp),
        .hrdata_o (hrdata)
    );

endmodule

`default_nettype wire

// File: mem_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_asserts (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  state_i,
    input  logic [1:0]  htrans_i,
    input  logic [2:0]  hsize_i,
    input  logic [31:0] hwdata_i,
    input  logic        hready_i,
    input  logic        stallreq_i
);

    // encoding of the master's WRITE state
    localparam logic [1:0] st_write = 2'b10;

    // attributes settle one cycle after reset is released
    attrs_fixed_a: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (htrans_i == ahb_pkg::htrans_nonseq) &&
                         (hsize_i == ahb_pkg::hsize_word))
        else $error("htrans or hsize is not a nonseq word transfer");

    // write data must survive each wait state of the data phase
    hwdata_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == st_write) && !hready_i |=> $stable(hwdata_i))
        else $error("hwdata changed while hready was low in a write");

    stallreq_on_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
        !hready_i |-> stallreq_i)
        else $error("stallreq low while hready was low");

endmodule

`default_nettype wire

// File: mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    localparam int mem_words    = 256;
    localparam int clk_period   = 20;
    localparam int window_words = 8;
    localparam int entry_limit  = 40;

    typedef struct packed {
        lsu_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [31:0]      hold;
        logic [31:0]      exp_data;
    } entry_t;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             req_i;
    lsu_pkg::mem_op_e op_i;
    logic [31:0]      addr_i;
    logic [31:0]      wdata_i;
    logic             hold_i;
    logic             done_o;
    logic [31:0]      load_data_o;

    entry_t     entries[$];
    logic [7:0] model_mem [mem_words*4];
    int         error_count = 0;
    int         check_count = 0;

    always #(clk_period / 2) clk = ~clk;

    mem_subsys #(
        .wait_states (1),
        .mem_words   (mem_words)
    ) mem_subsys_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .hold_i      (hold_i),
        .done_o      (done_o),
        .load_data_o (load_data_o)
    );

    bind ls_ahb_interface mem_subsys_asserts mem_subsys_asserts_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .state_i    (state),
        .htrans_i   (mst_htrans_o),
        .hsize_i    (mst_hsize_o),
        .hwdata_i   (mst_hwdata_o),
        .hready_i   (mst_hready_i),
        .stallreq_i (stallreq_o)
    );

    function automatic bit is_store(input lsu_pkg::mem_op_e op);
        return (op == lsu_pkg::op_sb) || (op == lsu_pkg::op_sh) || (op == lsu_pkg::op_sw);
    endfunction

    // byte-array memory model with the least significant byte at the lowest address
    function automatic logic [31:0] model_load(input lsu_pkg::mem_op_e op,
                                               input logic [31:0] addr);
        int          idx;
        logic [7:0]  b;
        logic [15:0] h;
        idx = addr % (mem_words * 4);
        b = model_mem[idx];
        h = {model_mem[idx + 1], model_mem[idx]};
        case (op)
            lsu_pkg::op_lb:  return {{24{b[7]}}, b};
            lsu_pkg::op_lbu: return {24'h0, b};
            lsu_pkg::op_lh:  return {{16{h[15]}}, h};
            lsu_pkg::op_lhu: return {16'h0, h};
            default:         return {model_mem[idx + 3], model_mem[idx + 2], h};
        endcase
    endfunction

    task automatic model_store(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] data);
        int idx;
        int n;
        idx = addr % (mem_words * 4);
        n = (op == lsu_pkg::op_sb) ? 1 : ((op == lsu_pkg::op_sh) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            model_mem[idx + i] = data[8*i +: 8];
        end
    endtask

    // loads take their expected value from the model at this point of the sequence
    task automatic add_entry(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input int hold);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.wdata    = wdata;
        e.hold     = hold;
        e.exp_data = '0;
        if (is_store(op)) begin
            model_store(op, addr, wdata);
        end else begin
            e.exp_data = model_load(op, addr);
        end
        entries.push_back(e);
    endtask

    task automatic add_random_entries(input int count);
        lsu_pkg::mem_op_e op;
        logic [31:0]      addr;
        int               hold;
        for (int k = 0; k < count; k++) begin
            case ($urandom % 8)
                0:       op = lsu_pkg::op_lb;
                1:       op = lsu_pkg::op_lh;
                2:       op = lsu_pkg::op_lw;
                3:       op = lsu_pkg::op_lbu;
                4:       op = lsu_pkg::op_lhu;
                5:       op = lsu_pkg::op_sb;
                6:       op = lsu_pkg::op_sh;
                default: op = lsu_pkg::op_sw;
            endcase
            addr = ($urandom % window_words) * 4;
            if ((op == lsu_pkg::op_lb) || (op == lsu_pkg::op_lbu) || (op == lsu_pkg::op_sb)) begin
                addr = addr + ($urandom % 4);
            end else if ((op == lsu_pkg::op_lh) || (op == lsu_pkg::op_lhu) ||
                         (op == lsu_pkg::op_sh)) begin
                addr = addr + ($urandom % 2) * 2;
            end
            hold = 0;
            if (($urandom % 4) == 0) begin
                hold = 1 + int'($urandom % 5);
            end
            add_entry(op, addr, $urandom, hold);
        end
    endtask

    task automatic build_table();
        // untouched word after reset
        add_entry(lsu_pkg::op_lw, 32'h3fc, 32'h0, 0);
        add_entry(lsu_pkg::op_sw, 32'h10, 32'h807f_f012, 0);
        add_entry(lsu_pkg::op_lw, 32'h10, 32'h0, 0);
        // top bit set in byte lanes 1 and 3 and clear in lanes 0 and 2
        add_entry(lsu_pkg::op_lb, 32'h10, 32'h0, 0);
        add_entry(lsu_pkg::op_lb, 32'h11, 32'h0, 0);
        add_entry(lsu_pkg::op_lbu, 32'h11, 32'h0, 0);
        add_entry(lsu_pkg::op_lbu, 32'h12, 32'h0, 0);
        add_entry(lsu_pkg::op_lb, 32'h13, 32'h0, 0);
        add_entry(lsu_pkg::op_sw, 32'h20, 32'h7ffe_8001, 0);
        add_entry(lsu_pkg::op_lh, 32'h20, 32'h0, 0);
        add_entry(lsu_pkg::op_lhu, 32'h20, 32'h0, 0);
        add_entry(lsu_pkg::op_lh, 32'h22, 32'h0, 0);
        add_entry(lsu_pkg::op_lhu, 32'h22, 32'h0, 0);
        // read-modify-write stores with some under back-pressure
        add_entry(lsu_pkg::op_sb, 32'h11, 32'h0000_00a5, 3);
        add_entry(lsu_pkg::op_lw, 32'h10, 32'h0, 0);
        add_entry(lsu_pkg::op_sh, 32'h12, 32'h0000_1234, 5);
        add_entry(lsu_pkg::op_lw, 32'h10, 32'h0, 0);
        add_entry(lsu_pkg::op_sb, 32'h23, 32'h0000_00c3, 0);
        add_entry(lsu_pkg::op_sh, 32'h20, 32'h0000_beef, 2);
        add_entry(lsu_pkg::op_lw, 32'h20, 32'h0, 4);
        add_entry(lsu_pkg::op_sw, 32'h24, 32'h0f1e_2d3c, 6);
        add_entry(lsu_pkg::op_lw, 32'h24, 32'h0, 7);
        add_entry(lsu_pkg::op_lbu, 32'h25, 32'h0, 3);
        // fill the random window before mixed traffic over it
        for (int k = 0; k < window_words; k++) begin
            add_entry(lsu_pkg::op_sw, k * 4, $urandom, 0);
        end
        add_random_entries(40);
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        int     cycles;
        bit     seen;
        e = entries[idx];
        cycles = 0;
        seen = 1'b0;
        req_i   <= 1'b1;
        op_i    <= e.op;
        addr_i  <= e.addr;
        wdata_i <= e.wdata;
        hold_i  <= (e.hold != 0);
        while (!seen && (cycles < int'(e.hold) + entry_limit)) begin
            @(negedge clk);
            if (done_o) begin
                seen = 1'b1;
                if (hold_i) begin
                    $display("entry %0d at %0t: done_o pulsed while hold_i was high", idx, $time);
                    error_count++;
                end
                if ((cycles < 3) && ((e.op == lsu_pkg::op_lw) || (e.op == lsu_pkg::op_sw))) begin
                    $display("entry %0d at %0t: done_o came after only %0d cycles",
                             idx, $time, cycles);
                    error_count++;
                end
                if (!is_store(e.op)) begin
                    check_count++;
                    if (load_data_o !== e.exp_data) begin
                        $display("mismatch at %0t: load_data_o expected %h actual %h (entry %0d)",
                                 $time, e.exp_data, load_data_o, idx);
                        error_count++;
                    end
                end
            end
            @(posedge clk);
            cycles++;
            if (cycles >= int'(e.hold)) begin
                hold_i <= 1'b0;
            end
        end
        if (!seen) begin
            $display("entry %0d: no done_o within %0d cycles", idx, cycles);
            error_count++;
        end
    endtask

    initial begin
        void'($urandom(19));
        rst_n   <= 1'b0;
        req_i   <= 1'b0;
        op_i    <= lsu_pkg::op_lw;
        addr_i  <= '0;
        wdata_i <= '0;
        hold_i  <= 1'b0;
        // the SRAM clears itself at reset
        for (int i = 0; i < mem_words * 4; i++) begin
            model_mem[i] = 8'h00;
        end
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < entries.size(); i++) begin
            run_entry(i);
        end
        req_i <= 1'b0;
        @(posedge clk);
        $display("entries: %0d, load checks: %0d, errors: %0d",
                 entries.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // table size is final once time zero has passed
    initial begin
        #1;
        repeat (entries.size() * 50) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", entries.size() * 50);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_subsys.f
ahb_pkg.sv
lsu_pkg.sv
mem_stage.sv
ls_ahb_interface.sv
ahb_sram_slave.sv
mem_subsys.sv
mem_subsys_asserts.sv
mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_subsys_tb \
    -f mem_subsys.f -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mem_subsys_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
